//--- axi_write_port.sv
`timescale 1ns/100ps
`default_nettype none

module axi_write_port (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire l2w_pkg::addr_t m_addr,
    input  wire l2w_pkg::word_t m_data,
    input  wire l2w_pkg::len_t  m_len,
    input  wire l2w_pkg::strb_t m_strb,
    input  wire                 m_avalid,
    input  wire                 m_wvalid,
    input  wire                 m_last,
    input  wire                 m_bready,
    output logic                m_aok,
    output logic                m_wready,
    output logic                m_bvalid,
    output logic                awvalid,
    input  wire                 awready,
    output l2w_pkg::addr_t      awaddr,
    output l2w_pkg::len_t       awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic                wvalid,
    input  wire                 wready,
    output l2w_pkg::word_t      wdata,
    output l2w_pkg::strb_t      wstrb,
    output logic                wlast,
    input  wire                 bvalid,
    output logic                bready
);
    logic aw_sent;
    logic w_done;

    // the requester keeps its address strobe up until the last beat,
    // so one address per burst is enforced here
    assign awvalid = m_avalid && !aw_sent;
    assign awaddr  = m_addr;
    assign awlen   = m_len;
    assign awsize  = 3'b010;                     // 4 bytes per beat.
    assign awburst = 2'b01;                      // incr.

    assign wvalid  = m_wvalid;
    assign wdata   = m_data;
    assign wstrb   = m_strb;
    assign wlast   = m_last;

    assign bready  = m_bready;

    assign m_aok    = awvalid && awready;
    assign m_wready = wvalid && wready;
    assign m_bvalid = bvalid && bready;
    assign w_done   = m_wready && wlast;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aw_sent <= 1'b0;
        end else if (w_done) begin
            aw_sent <= 1'b0;                     // next burst may issue its address.
        end else if (m_aok) begin
            aw_sent <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- l2_write_path.sv
`timescale 1ns/100ps
`default_nettype none

module l2_write_path (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 req,
    input  wire l2w_pkg::addr_t addr,
    input  wire l2w_pkg::line_t line,
    input  wire                 dma_sign,
    input  wire l2w_pkg::strb_t req_wstrb,  // cache strobe for uncached writes.
    output logic                ack,
    output logic                dma_lock,
    output logic                awvalid,
    input  wire                 awready,
    output l2w_pkg::addr_t      awaddr,
    output l2w_pkg::len_t       awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic                wvalid,
    input  wire                 wready,
    output l2w_pkg::word_t      wdata,
    output l2w_pkg::strb_t      wstrb,
    output logic                wlast,
    input  wire                 bvalid,
    output logic                bready
);
    import l2w_pkg::*;

    logic  wb_req;
    addr_t wb_addr;
    line_t wb_line;
    logic  wb_ok;
    logic  wrt_lock;

    logic  bf_awvalid;
    logic  bf_wvalid;
    addr_t bf_addr;
    word_t bf_data;
    logic  bf_last;
    logic  bf_bready;
    logic  bf_awok;
    logic  bf_wready;
    logic  bf_bvalid;

    addr_t m_addr;
    word_t m_data;
    len_t  m_len;
    strb_t m_strb;
    logic  m_avalid;
    logic  m_wvalid;
    logic  m_last;
    logic  m_bready;
    logic  m_aok;
    logic  m_wready;
    logic  m_bvalid;

    write_arbiter u_arbiter (
        .wstrb (req_wstrb),
        .*
    );

    write_buffer u_buffer (.*);

    axi_write_port u_port (.*);

endmodule

`default_nettype wire

//--- l2w_pkg.sv
`default_nettype none

package l2w_pkg;

    localparam int OFFSET_WIDTH = 2;                 // log2 of words per line.
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;
    localparam int WBUF_DEPTH   = 2;                 // lines held in the write buffer.

    typedef logic [31:0]              addr_t;       // byte address.
    typedef logic [31:0]              word_t;
    typedef logic [LINE_WORDS*32-1:0] line_t;       // word 0 sits in the low bits.
    typedef logic [3:0]               strb_t;
    typedef logic [7:0]               len_t;        // beats minus one.

    // owner of the shared write channel
    typedef enum logic [2:0] {
        IDLE,
        WRT_W,
        DMA_AW,
        DMA_W,
        DMA_R
    } arb_state_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tb.f
l2w_pkg.sv
write_buffer.sv
write_arbiter.sv
axi_write_port.sv
l2_write_path.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

//--- tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 req,
    input  wire l2w_pkg::addr_t addr,
    input  wire l2w_pkg::line_t line,
    input  wire                 dma_sign,
    input  wire l2w_pkg::strb_t req_wstrb,
    input  wire                 ack,
    input  wire                 dma_lock,
    input  wire                 awvalid,
    input  wire                 awready,
    input  wire l2w_pkg::addr_t awaddr,
    input  wire l2w_pkg::len_t  awlen,
    input  wire [2:0]           awsize,
    input  wire [1:0]           awburst,
    input  wire                 wvalid,
    input  wire                 wready,
    input  wire l2w_pkg::word_t wdata,
    input  wire l2w_pkg::strb_t wstrb,
    input  wire                 wlast,
    input  wire                 bvalid,
    input  wire                 bready,
    input  wire [7:0]           test_id,
    input  wire                 test_end,
    output int                  outstanding,
    output int                  errors,
    output int                  tests_run,
    output int                  tests_failed
);
    import l2w_pkg::*;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        len_t  beats;
        line_t data;
        strb_t strb;
        logic  strb_ok;                      // same strobe on every beat.
        logic  last_ok;                      // wlast on the final beat only.
    } burst_t;

    burst_t exp_q[$];
    burst_t got_q[$];
    burst_t cur;
    logic   in_burst;
    int     beat_idx;
    int     pending_wb;                      // acked writebacks still waiting for B.
    int     test_errs;
    int     wb_acks;
    int     b_done;
    logic   lock_seen;
    logic   aw_hold;
    logic   w_hold;
    addr_t  held_addr;
    word_t  held_data;
    strb_t  held_strb;
    logic   held_last;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "writeback_only";
            8'd2:    return "uncached_only";
            8'd3:    return "mixed_order";
            8'd4:    return "backpressure";
            8'd5:    return "buffer_full";
            default: return "setup";
        endcase
    endfunction

    // a writeback drains its whole aligned line, an uncached write is one beat
    function automatic burst_t expected_burst(
        input addr_t a,
        input line_t l,
        input logic  dma,
        input strb_t s
    );
        burst_t b;
        b         = '0;
        b.strb_ok = 1'b1;
        b.last_ok = 1'b1;
        if (dma) begin
            b.addr       = a;
            b.beats      = 8'd1;
            b.data[31:0] = l[31:0];
            b.strb       = s;
        end else begin
            b.addr  = a & ~addr_t'(LINE_WORDS * 4 - 1);
            b.len   = len_t'(LINE_WORDS - 1);
            b.beats = len_t'(LINE_WORDS);
            b.data  = l;
            b.strb  = 4'hF;
        end
        return b;
    endfunction

    task automatic report_fault(input string msg);
        errors++;
        test_errs++;
        $display("%s: %s", test_name(test_id), msg);
    endtask

    task automatic report_mismatch(input string what, input line_t e, input line_t a);
        errors++;
        test_errs++;
        $display("Error %s %s: expected %0h, actual %0h", test_name(test_id), what, e, a);
    endtask

    task automatic compare_burst(input burst_t e, input burst_t g);
        if (g.addr != e.addr) begin
            report_mismatch("address", line_t'(e.addr), line_t'(g.addr));
        end
        if (g.len != e.len) begin
            report_mismatch("length", line_t'(e.len), line_t'(g.len));
        end
        if (g.beats != e.beats) begin
            report_mismatch("beat count", line_t'(e.beats), line_t'(g.beats));
        end
        if (g.data != e.data) begin
            report_mismatch("data", e.data, g.data);
        end
        if (g.strb != e.strb || !g.strb_ok) begin
            report_mismatch("strobe", line_t'(e.strb), line_t'(g.strb));
        end
        if (!g.last_ok) begin
            report_fault("wlast was not on the final beat only");
        end
    endtask

    // sampled mid-cycle, each handshake completes at the next rising edge
    always @(negedge clk) begin
        if (!rstn) begin
            in_burst   = 1'b0;
            lock_seen  = 1'b0;
            aw_hold    = 1'b0;
            w_hold     = 1'b0;
            beat_idx   = 0;
            pending_wb = 0;
            if (ack || dma_lock || awvalid || wvalid || bready) begin
                report_fault("outputs were not low during reset");
            end
        end else begin
            if (aw_hold && (!awvalid || awaddr != held_addr)) begin
                report_fault("address changed or dropped before awready");
            end
            if (w_hold && (!wvalid || wdata != held_data || wstrb != held_strb ||
                           wlast != held_last)) begin
                report_fault("write data changed or dropped before wready");
            end
            aw_hold   = awvalid && !awready;
            w_hold    = wvalid && !wready;
            held_addr = awaddr;
            held_data = wdata;
            held_strb = wstrb;
            held_last = wlast;

            if (awvalid && awready) begin
                if (in_burst) begin
                    report_fault("second address handshake within one burst");
                end
                if (dma_lock && pending_wb != 0) begin
                    report_fault("uncached write started while the buffer held lines");
                end
                if (awsize != 3'b010 || awburst != 2'b01) begin
                    report_fault("wrong awsize or awburst");
                end
                cur         = '0;
                cur.addr    = awaddr;
                cur.len     = awlen;
                cur.strb_ok = 1'b1;
                cur.last_ok = 1'b1;
                in_burst    = 1'b1;
                beat_idx    = 0;
            end
            if (wvalid && wready) begin
                if (!in_burst) begin
                    report_fault("write beat before its address");
                end
                if (beat_idx < LINE_WORDS) begin
                    cur.data[32*beat_idx +: 32] = wdata;
                end
                if (beat_idx == 0) begin
                    cur.strb = wstrb;
                end else if (wstrb != cur.strb) begin
                    cur.strb_ok = 1'b0;
                end
                if (wlast != (beat_idx == int'(cur.len))) begin
                    cur.last_ok = 1'b0;
                end
                beat_idx++;
                cur.beats = len_t'(beat_idx);
            end
            if (bvalid && bready) begin
                if (!in_burst) begin
                    report_fault("write response without a burst");
                end else begin
                    got_q.push_back(cur);
                    b_done++;
                    if (cur.len != '0) begin
                        pending_wb--;
                    end
                end
                in_burst = 1'b0;
            end

            if (ack && !req) begin
                report_fault("ack without a request");
            end
            if (req && ack) begin
                exp_q.push_back(expected_burst(addr, line, dma_sign, req_wstrb));
                if (!dma_sign) begin
                    if (pending_wb >= WBUF_DEPTH) begin
                        report_fault("writeback accepted while the buffer was full");
                    end
                    pending_wb++;
                    wb_acks++;
                    if (test_id == 8'd5 && wb_acks == 3 && b_done == 0) begin
                        report_fault("third writeback acknowledged before the first response");
                    end
                end
            end
            if (req && dma_sign) begin
                if (lock_seen && !dma_lock) begin
                    report_fault("dma_lock dropped before ack");
                end
                if (ack && !dma_lock) begin
                    report_fault("uncached ack without dma_lock");
                end
                lock_seen = dma_lock && !ack;
            end else if (dma_lock) begin
                report_fault("dma_lock high without an uncached request");
            end

            while (exp_q.size() > 0 && got_q.size() > 0) begin
                compare_burst(exp_q.pop_front(), got_q.pop_front());
            end

            if (test_end) begin
                if (exp_q.size() != 0 || got_q.size() != 0 || in_burst) begin
                    report_fault("bursts missing or left over at the end of the test");
                end
                $display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                         (test_errs == 0) ? "pass" : "fail", test_errs);
                tests_run++;
                if (test_errs != 0) begin
                    tests_failed++;
                end
                test_errs = 0;
                wb_acks   = 0;
                b_done    = 0;
                exp_q.delete();
                got_q.delete();
            end
        end
        outstanding = exp_q.size() + got_q.size();
    end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk
);
    localparam int HALF_NS = 2;              // 4 ns period.

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_NS) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;
    import l2w_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_REQ    = 20 + 20 + 60 + 20 + 3;
    localparam int WATCH_CYCLES = RESET_CYCLES + TOTAL_REQ * 200;

    logic        clk;
    logic        rstn      = 1'b0;
    logic        req       = 1'b0;
    addr_t       addr      = '0;
    line_t       line      = '0;
    logic        dma_sign  = 1'b0;
    strb_t       req_wstrb = '0;
    logic        awready   = 1'b0;
    logic        wready    = 1'b0;
    logic        bvalid    = 1'b0;
    logic [7:0]  test_id   = '0;
    logic        test_end  = 1'b0;
    logic        slow_aw   = 1'b0;          // rare awready.
    logic        long_b    = 1'b0;          // late responses, fills the buffer.
    logic        ack;
    logic        dma_lock;
    logic        awvalid;
    addr_t       awaddr;
    len_t        awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic        wvalid;
    word_t       wdata;
    strb_t       wstrb;
    logic        wlast;
    logic        bready;
    int          outstanding;
    int          errors;
    int          tests_run;
    int          tests_failed;

    tb_clkgen u_clkgen (.clk(clk));

    l2_write_path UUT (.*);

    tb_checker u_checker (.*);

    always @(posedge clk) begin
        if (slow_aw) begin
            awready <= ($urandom % 16) == 0;
        end else begin
            awready <= ($urandom % 2) == 0;
        end
        wready <= ($urandom % 2) == 0;
    end

    // one response per burst, some cycles after the last beat
    initial begin
        int unsigned delay;
        forever begin
            @(negedge clk);
            if (wvalid && wready && wlast) begin
                delay = long_b ? 20 : $urandom_range(4, 1);
                repeat (delay) @(posedge clk);
                bvalid <= 1'b1;
                do begin
                    @(negedge clk);
                end while (!bready);
                @(posedge clk);
                bvalid <= 1'b0;
            end
        end
    end

    // mode 0 writeback, 1 uncached, 2 either
    task automatic send_request(input int mode, input int unsigned gap_max);
        int          i;
        int unsigned gap;
        line_t       l;
        logic        dma;
        l = '0;
        for (i = 0; i < LINE_WORDS; i++) begin
            l[32*i +: 32] = $urandom;
        end
        dma = (mode == 2) ? (($urandom % 2) == 0) : (mode == 1);
        gap = $urandom_range(gap_max);
        @(posedge clk);
        req       <= 1'b1;
        addr      <= $urandom;
        line      <= l;
        dma_sign  <= dma;
        req_wstrb <= strb_t'($urandom_range(15, 1));
        do begin
            @(negedge clk);
        end while (!ack);
        @(posedge clk);
        req <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic run_test(
        input logic [7:0]  id,
        input int          count,
        input int          mode,
        input logic        aw_slow,
        input logic        b_long,
        input int unsigned gap_max
    );
        int n;
        @(posedge clk);
        test_id <= id;
        slow_aw <= aw_slow;
        long_b  <= b_long;
        for (n = 0; n < count; n++) begin
            send_request(mode, gap_max);
        end
        @(posedge clk);
        while (outstanding != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        void'($urandom(61249));
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        run_test(8'd1, 20, 0, 1'b0, 1'b0, 3);
        run_test(8'd2, 20, 1, 1'b0, 1'b0, 3);
        run_test(8'd3, 60, 2, 1'b0, 1'b0, 3);
        run_test(8'd4, 20, 2, 1'b1, 1'b0, 3);
        run_test(8'd5, 3, 0, 1'b0, 1'b1, 0);
        @(posedge clk);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run == 5) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- write_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module write_arbiter (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 req,
    input  wire l2w_pkg::addr_t addr,
    input  wire l2w_pkg::line_t line,
    input  wire                 dma_sign,
    input  wire l2w_pkg::strb_t wstrb,
    output logic                ack,
    output logic                dma_lock,
    output logic                wb_req,
    output l2w_pkg::addr_t      wb_addr,
    output l2w_pkg::line_t      wb_line,
    input  wire                 wb_ok,
    input  wire                 wrt_lock,
    input  wire                 bf_awvalid,
    input  wire                 bf_wvalid,
    input  wire l2w_pkg::addr_t bf_addr,
    input  wire l2w_pkg::word_t bf_data,
    input  wire                 bf_last,
    input  wire                 bf_bready,
    output logic                bf_awok,
    output logic                bf_wready,
    output logic                bf_bvalid,
    output l2w_pkg::addr_t      m_addr,
    output l2w_pkg::word_t      m_data,
    output l2w_pkg::len_t       m_len,
    output l2w_pkg::strb_t      m_strb,
    output logic                m_avalid,
    output logic                m_wvalid,
    output logic                m_last,
    output logic                m_bready,
    input  wire                 m_aok,
    input  wire                 m_wready,
    input  wire                 m_bvalid
);
    import l2w_pkg::*;

    arb_state_t state;
    arb_state_t nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= nxt;
        end
    end

    always_comb begin
        nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    if (!dma_sign) begin
                        nxt = WRT_W;
                    end else if (!wrt_lock) begin
                        nxt = DMA_AW;            // uncached write waits for an empty buffer.
                    end
                end
            end
            WRT_W: begin
                if (wb_ok) begin
                    nxt = IDLE;
                end
            end
            DMA_AW: begin
                if (m_aok) begin
                    nxt = DMA_W;
                end
            end
            DMA_W: begin
                if (m_wready) begin
                    nxt = DMA_R;
                end
            end
            DMA_R: begin
                if (m_bvalid) begin
                    nxt = IDLE;
                end
            end
            default: nxt = IDLE;
        endcase
    end

    always_comb begin
        ack       = 1'b0;
        dma_lock  = 1'b0;
        wb_req    = 1'b0;
        wb_addr   = '0;
        wb_line   = '0;
        bf_awok   = 1'b0;
        bf_wready = 1'b0;
        bf_bvalid = 1'b0;
        m_addr    = '0;
        m_data    = '0;
        m_len     = '0;
        m_strb    = '0;
        m_avalid  = 1'b0;
        m_wvalid  = 1'b0;
        m_last    = 1'b0;
        m_bready  = 1'b0;
        case (state)
            IDLE, WRT_W: begin
                // buffer drain owns the channel
                m_len     = len_t'(LINE_WORDS - 1);
                m_strb    = 4'hF;
                m_addr    = bf_addr;
                m_data    = bf_data;
                m_avalid  = bf_awvalid;
                m_wvalid  = bf_wvalid;
                m_last    = bf_last;
                m_bready  = bf_bready;
                bf_awok   = m_aok;
                bf_wready = m_wready;
                bf_bvalid = m_bvalid;
                if (state == WRT_W) begin
                    wb_req  = req;
                    wb_addr = addr;
                    wb_line = line;
                    ack     = wb_ok;
                end
            end
            DMA_AW, DMA_W: begin
                m_len    = '0;
                m_strb   = wstrb;
                m_addr   = addr;
                m_data   = line[31:0];           // low word only.
                m_avalid = 1'b1;
                m_wvalid = (state == DMA_W);
                m_last   = (state == DMA_W);
                dma_lock = 1'b1;
            end
            DMA_R: begin
                m_len    = '0;
                m_strb   = wstrb;
                m_bready = 1'b1;
                ack      = m_bvalid;
                dma_lock = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- write_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module write_buffer (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 wb_req,
    input  wire l2w_pkg::addr_t wb_addr,
    input  wire l2w_pkg::line_t wb_line,
    output logic                wb_ok,
    output logic                wrt_lock,
    output logic                bf_awvalid,
    output logic                bf_wvalid,
    output l2w_pkg::addr_t      bf_addr,
    output l2w_pkg::word_t      bf_data,
    output logic                bf_last,
    input  wire                 bf_awok,
    input  wire                 bf_wready,
    input  wire                 bf_bvalid,
    output logic                bf_bready
);
    import l2w_pkg::*;

    typedef enum logic [1:0] {
        D_ADDR,
        D_DATA,
        D_RESP
    } wbuf_state_t;

    wbuf_state_t                   state;
    logic [$clog2(WBUF_DEPTH)-1:0] head;
    logic [$clog2(WBUF_DEPTH)-1:0] tail;
    logic [$clog2(WBUF_DEPTH):0]   count;
    logic [OFFSET_WIDTH-1:0]       beat;
    addr_t                         addr_q [WBUF_DEPTH];
    line_t                         line_q [WBUF_DEPTH];
    logic                          empty;
    logic                          full;
    logic                          push;
    logic                          pop;

    function automatic logic [$clog2(WBUF_DEPTH)-1:0] next_ptr(
        input logic [$clog2(WBUF_DEPTH)-1:0] ptr
    );
        return (ptr == $bits(ptr)'(WBUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == $bits(count)'(WBUF_DEPTH));
    assign push     = wb_req && !full;
    assign pop      = (state == D_RESP) && bf_bvalid;    // entry leaves on the response.
    assign wb_ok    = push;
    assign wrt_lock = !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[tail] <= {wb_addr[31:OFFSET_WIDTH+2], {(OFFSET_WIDTH+2){1'b0}}};
            line_q[tail] <= wb_line;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // drain of the head entry, one burst at a time
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= D_ADDR;
            beat  <= '0;
        end else begin
            case (state)
                D_ADDR: begin
                    if (!empty && bf_awok) begin
                        state <= D_DATA;
                    end
                end
                D_DATA: begin
                    if (bf_wready) begin
                        beat <= beat + 1'b1;
                        if (bf_last) begin
                            beat  <= '0;
                            state <= D_RESP;
                        end
                    end
                end
                D_RESP: begin
                    if (bf_bvalid) begin
                        state <= D_ADDR;
                    end
                end
                default: state <= D_ADDR;
            endcase
        end
    end

    // address strobe stays up through the data phase.
    assign bf_awvalid = ((state == D_ADDR) && !empty) || (state == D_DATA);
    assign bf_wvalid  = (state == D_DATA);
    assign bf_addr    = addr_q[head];
    assign bf_data    = line_q[head][32*beat +: 32];
    assign bf_last    = (beat == OFFSET_WIDTH'(LINE_WORDS - 1));
    assign bf_bready  = (state == D_RESP);

endmodule

`default_nettype wire
